//--- rtl/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath width of operands and result
`define ALU_WIDTH 32

// log2 of ALU_WIDTH
// amounts at or above ALU_WIDTH need more bits than this
`define ALU_SHAMT_BITS 5

`endif

//--- rtl/alu_pkg.sv
package alu_pkg;

	// operation codes as the control path encodes them
	typedef enum logic [2:0] {
		NOP = 3'd0, // all outputs zero
		ADD = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		OR  = 3'd4,
		XOR = 3'd5,
		SLT = 3'd6, // unsigned set less than
		SLL = 3'd7  // logical left shift
	} alu_op_t;

	// which unit answers for an op
	typedef enum logic [1:0] {
		CLASS_NONE  = 2'd0, // nop
		CLASS_ARITH = 2'd1, // add/sub unit
		CLASS_LOGIC = 2'd2  // logic/shift unit
	} alu_class_t;

	// map op code to its class
	function automatic alu_class_t op_class(alu_op_t op);
		case (op)
			ADD, SUB:
				return CLASS_ARITH;
			AND, OR, XOR, SLT, SLL:
				return CLASS_LOGIC;
			default:
				return CLASS_NONE; // nop lands here
		endcase
	endfunction

endpackage

//--- rtl/alu_arith_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

// add/subtract unit
// one shared adder, operand1 inverted and carry-in set for sub
module alu_arith_unit (
	input  logic                    clk,          // assertion sampling only
	input  logic [`ALU_WIDTH-1:0]   operand0,
	input  logic [`ALU_WIDTH-1:0]   operand1,
	input  alu_pkg::alu_op_t        op,
	output logic [`ALU_WIDTH-1:0]   arith_result,
	output logic                    arith_v,      // signed overflow
	output logic                    arith_c       // carry out of top bit
);

	import alu_pkg::*;

	logic                  sub_sel;   // high only for SUB
	logic [`ALU_WIDTH-1:0] addend1;   // operand1 or its complement
	logic [`ALU_WIDTH:0]   sum_ext;   // one extra bit for carry out
	logic                  op0_msb;
	logic                  add1_msb;
	logic                  res_msb;

	// anything that is not SUB goes through as an add
	assign sub_sel = (op == SUB);

	// a - b == a + ~b + 1
	assign addend1 = sub_sel ? ~operand1 : operand1;

	// zero-extend both sides so the carry lands in the extra bit
	assign sum_ext = {1'b0, operand0}
		+ {1'b0, addend1}
		+ {{`ALU_WIDTH{1'b0}}, sub_sel}; // carry-in

	assign arith_result = sum_ext[`ALU_WIDTH-1:0];

	// for sub this is the "no borrow" bit
	// set when operand0 >= operand1 unsigned, including 0 - 0
	assign arith_c = sum_ext[`ALU_WIDTH];

	// sign bits, taken from the adder inputs so add and sub share one rule
	assign op0_msb  = operand0[`ALU_WIDTH-1];
	assign add1_msb = addend1[`ALU_WIDTH-1];
	assign res_msb  = arith_result[`ALU_WIDTH-1];

	// overflow when adder inputs agree in sign and the sum does not
	// for sub that means operands differ in sign and result sign != operand0 sign
	assign arith_v = ~(op0_msb ^ add1_msb) & (op0_msb ^ res_msb);

	// flags must be known whenever the combiner will take them
	a_flags_known: assert property (
		@(posedge clk) (op inside {ADD, SUB}) |-> !$isunknown({arith_v, arith_c})
	) else $error("arith flags unknown for op %0d", op);

endmodule

//--- rtl/alu_logic_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

// bitwise ops, unsigned set less than, logical left shift
module alu_logic_unit (
	input  logic                    clk,       // assertion sampling only
	input  logic [`ALU_WIDTH-1:0]   operand0,
	input  logic [`ALU_WIDTH-1:0]   operand1,  // also the shift amount for SLL
	input  alu_pkg::alu_op_t        op,
	output logic [`ALU_WIDTH-1:0]   logic_result
);

	import alu_pkg::*;

	logic                      shamt_big;   // shift of ALU_WIDTH or more
	logic [`ALU_SHAMT_BITS-1:0] shamt;      // low bits of the amount
	logic                      lt_u;        // unsigned compare

	// any bit above the shift field means everything falls off the top
	assign shamt_big = |operand1[`ALU_WIDTH-1:`ALU_SHAMT_BITS];
	assign shamt     = operand1[`ALU_SHAMT_BITS-1:0];

	// slt compares as unsigned
	assign lt_u = (operand0 < operand1);

	always_comb begin
		case (op)
			AND:
				logic_result = operand0 & operand1;
			OR:
				logic_result = operand0 | operand1;
			XOR:
				logic_result = operand0 ^ operand1;
			SLT:
				logic_result = {{(`ALU_WIDTH-1){1'b0}}, lt_u}; // 0 or 1
			SLL: begin
				if (shamt_big)
					logic_result = '0;
				else
					logic_result = operand0 << shamt;
			end
			default:
				logic_result = '0; // nop, add, sub handled elsewhere
		endcase
	end

	// shifting the answer back recovers operand0 less the bits pushed out
	a_sll_round_trip: assert property (
		@(posedge clk) (op == SLL && !shamt_big)
			|-> ((logic_result >> shamt) == (operand0 & ({`ALU_WIDTH{1'b1}} >> shamt)))
	) else $error("sll result %h does not shift back to %h", logic_result, operand0);

endmodule

//--- rtl/alu_result_combine.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

// picks the answer by op class, builds flags, one register stage
module alu_result_combine (
	input  logic                    clk,
	input  logic                    reset,
	input  alu_pkg::alu_op_t        op,
	input  logic                    op_valid,
	input  logic [`ALU_WIDTH-1:0]   arith_result,
	input  logic [`ALU_WIDTH-1:0]   logic_result,
	input  logic                    arith_v,
	input  logic                    arith_c,
	output logic [`ALU_WIDTH-1:0]   result,
	output logic                    z,
	output logic                    v,
	output logic                    c,
	output logic                    n,
	output logic                    result_valid
);

	import alu_pkg::*;

	alu_class_t            op_cls;      // class of the incoming op
	alu_class_t            result_cls;  // class of what sits in the output regs
	logic [`ALU_WIDTH-1:0] sel_result;
	logic                  sel_z;
	logic                  sel_v;
	logic                  sel_c;
	logic                  sel_n;

	assign op_cls = op_class(op);

	// v/c only mean something for arithmetic
	always_comb begin
		case (op_cls)
			CLASS_ARITH: begin
				sel_result = arith_result;
				sel_v      = arith_v;
				sel_c      = arith_c;
			end
			CLASS_LOGIC: begin
				sel_result = logic_result;
				sel_v      = 1'b0; // masked
				sel_c      = 1'b0;
			end
			default: begin
				sel_result = '0; // nop
				sel_v      = 1'b0;
				sel_c      = 1'b0;
			end
		endcase
	end

	// nop reports z=0 even with a zero result
	assign sel_z = (op_cls != CLASS_NONE) && (sel_result == '0);
	assign sel_n = sel_result[`ALU_WIDTH-1]; // sign of whatever was picked

	always_ff @(posedge clk) begin
		if (reset) begin
			result       <= '0;
			z            <= 1'b0;
			v            <= 1'b0;
			c            <= 1'b0;
			n            <= 1'b0;
			result_valid <= 1'b0;
			result_cls   <= CLASS_NONE;
		end else begin
			result_valid <= op_valid; // single cycle pulse per op
			if (op_valid) begin
				result     <= sel_result;
				z          <= sel_z;
				v          <= sel_v;
				c          <= sel_c;
				n          <= sel_n;
				result_cls <= op_cls;
			end // otherwise hold last values
		end
	end

	// a zero result never looks negative
	a_z_n_exclusive: assert property (
		@(posedge clk) result_valid |-> !(z && n)
	) else $error("z and n both set for result %h", result);

	// carry or overflow can only come from the add/sub path
	a_vc_only_arith: assert property (
		@(posedge clk) (result_valid && (c || v)) |-> (result_cls == CLASS_ARITH)
	) else $error("v/c set for non-arith class %0d", result_cls);

endmodule

//--- rtl/alu_top.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

// alu stage, both units run in parallel, combiner registers the answer
module alu_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    op_valid,   // one strobe per op
	input  logic [`ALU_WIDTH-1:0]   operand0,
	input  logic [`ALU_WIDTH-1:0]   operand1,
	input  alu_pkg::alu_op_t        op,
	output logic [`ALU_WIDTH-1:0]   result,
	output logic                    z,
	output logic                    v,
	output logic                    c,
	output logic                    n,
	output logic                    result_valid // one cycle after op_valid
);

	// unit outputs into the combiner
	logic [`ALU_WIDTH-1:0] arith_result;
	logic                  arith_v;
	logic                  arith_c;
	logic [`ALU_WIDTH-1:0] logic_result;

	alu_arith_unit u_arith (
		.clk          (clk),
		.operand0     (operand0),
		.operand1     (operand1),
		.op           (op),
		.arith_result (arith_result),
		.arith_v      (arith_v),
		.arith_c      (arith_c)
	);

	alu_logic_unit u_logic (
		.clk          (clk),
		.operand0     (operand0),
		.operand1     (operand1),
		.op           (op),
		.logic_result (logic_result)
	);

	// class select, flag build and output register
	alu_result_combine u_combine (
		.clk          (clk),
		.reset        (reset),
		.op           (op),
		.op_valid     (op_valid),
		.arith_result (arith_result),
		.logic_result (logic_result),
		.arith_v      (arith_v),
		.arith_c      (arith_c),
		.result       (result),
		.z            (z),
		.v            (v),
		.c            (c),
		.n            (n),
		.result_valid (result_valid)
	);

endmodule

//--- test/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

`include "alu_macros.svh"

// expected alu behavior, written straight from the op and flag rules
// the including module imports alu_pkg for the op codes

// result of op applied to a and b
function automatic logic [`ALU_WIDTH-1:0] model_result(alu_op_t op,
	logic [`ALU_WIDTH-1:0] a, logic [`ALU_WIDTH-1:0] b);
	case (op)
		ADD: return a + b; // wraps at the width
		SUB: return a - b;
		AND: return a & b;
		OR:  return a | b;
		XOR: return a ^ b;
		SLT: return {{(`ALU_WIDTH-1){1'b0}}, (a < b)}; // unsigned order
		SLL: begin
			if (b >= `ALU_WIDTH)
				return '0; // everything shifted out
			return a << b;
		end
		default: return '0; // nop
	endcase
endfunction

// signed overflow, add and sub only
function automatic logic overflow_flag(alu_op_t op,
	logic [`ALU_WIDTH-1:0] a, logic [`ALU_WIDTH-1:0] b);
	logic [`ALU_WIDTH-1:0] r;
	logic                  sa;
	logic                  sb;
	logic                  sr;
	r  = model_result(op, a, b);
	sa = a[`ALU_WIDTH-1];
	sb = b[`ALU_WIDTH-1];
	sr = r[`ALU_WIDTH-1];
	case (op)
		ADD: return (sa == sb) && (sr != sa); // same signs in, other sign out
		SUB: return (sa != sb) && (sr != sa);
		default: return 1'b0;
	endcase
endfunction

// carry out for add, no-borrow for sub
function automatic logic carry_flag(alu_op_t op,
	logic [`ALU_WIDTH-1:0] a, logic [`ALU_WIDTH-1:0] b);
	logic [`ALU_WIDTH:0] wide;
	wide = {1'b0, a} + {1'b0, b};
	case (op)
		ADD: return wide[`ALU_WIDTH];
		SUB: return (a >= b); // 0 - 0 gives 1
		default: return 1'b0;
	endcase
endfunction

// nop never reports zero
function automatic logic zero_flag(alu_op_t op, logic [`ALU_WIDTH-1:0] r);
	return (op != NOP) && (r == '0);
endfunction

function automatic logic negative_flag(logic [`ALU_WIDTH-1:0] r);
	return r[`ALU_WIDTH-1]; // top bit of the result
endfunction

`endif

//--- test/alu_tb.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

// table driven testbench for alu_top with an in-order result scoreboard
module alu_tb;

	import alu_pkg::*;

	localparam int W            = `ALU_WIDTH;
	localparam int CLK_PERIOD   = 100; // ns
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 3;   // quiet cycles before the first op
	localparam int NUM_RANDOM   = 48;
	localparam int SEED         = 24628;

	`include "alu_ref_model.svh"

	logic         clk;
	logic         reset;
	logic         op_valid;
	logic [W-1:0] operand0;
	logic [W-1:0] operand1;
	alu_op_t      op;
	logic [W-1:0] result;
	logic         z;
	logic         v;
	logic         c;
	logic         n;
	logic         result_valid;

	alu_op_t      tbl_op[$];
	logic [W-1:0] tbl_a[$];
	logic [W-1:0] tbl_b[$];
	bit           tbl_gap[$];          // idle cycle before this entry
	logic [W-1:0] tbl_exp_result[$];
	logic [3:0]   tbl_exp_flags[$];    // {z, v, c, n}
	int           pending[$];          // table indices in flight
	int           cur_idx;             // rides along with op_valid
	int           chk_idx;
	int           gap_count;
	int           results_seen;
	int           value_errors;
	int           protocol_errors;
	int           limit_ns;
	bit           table_ready;
	logic [W-1:0] last_result;         // outputs hold this between results
	logic [3:0]   last_flags;

	alu_top u_alu_top (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.operand0     (operand0),
		.operand1     (operand1),
		.op           (op),
		.result       (result),
		.z            (z),
		.v            (v),
		.c            (c),
		.n            (n),
		.result_valid (result_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// one table row with expected values from the model
	task automatic add_entry(input alu_op_t op_in, input logic [W-1:0] a,
		input logic [W-1:0] b, input bit gap);
		logic [W-1:0] r;
		r = model_result(op_in, a, b);
		tbl_op.push_back(op_in);
		tbl_a.push_back(a);
		tbl_b.push_back(b);
		tbl_gap.push_back(gap);
		tbl_exp_result.push_back(r);
		tbl_exp_flags.push_back({zero_flag(op_in, r), overflow_flag(op_in, a, b),
			carry_flag(op_in, a, b), negative_flag(r)});
		if (gap)
			gap_count++;
	endtask

	task automatic build_table();
		alu_op_t      rop;
		logic [W-1:0] ra;
		logic [W-1:0] rb;
		add_entry(ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b0); // max positive + 1
		add_entry(ADD, 32'h8000_0000, 32'hffff_ffff, 1'b0); // min negative + -1
		add_entry(ADD, 32'hffff_ffff, 32'h0000_0001, 1'b0); // wraps to zero
		add_entry(ADD, 32'h0000_0000, 32'h0000_0000, 1'b0);
		add_entry(SUB, 32'h0000_0000, 32'h0000_0000, 1'b0); // c=1
		add_entry(SUB, 32'h8000_0000, 32'h0000_0001, 1'b0); // min negative - 1
		add_entry(SUB, 32'h7fff_ffff, 32'hffff_ffff, 1'b0);
		add_entry(SUB, 32'h1234_5678, 32'h1234_5678, 1'b0); // equal
		add_entry(SUB, 32'h0000_0005, 32'h0000_0007, 1'b0); // borrow
		add_entry(AND, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0);
		add_entry(AND, 32'h0f0f_0f0f, 32'hf0f0_f0f0, 1'b0);
		add_entry(OR,  32'h8000_0000, 32'h0000_0001, 1'b0);
		add_entry(XOR, 32'ha5a5_a5a5, 32'ha5a5_a5a5, 1'b0);
		add_entry(XOR, 32'hffff_0000, 32'h0f0f_0f0f, 1'b0);
		add_entry(SLT, 32'h0000_0001, 32'h0000_0002, 1'b0);
		add_entry(SLT, 32'hffff_ffff, 32'h0000_0001, 1'b0); // signed less, unsigned not
		add_entry(SLT, 32'h0000_0001, 32'hffff_ffff, 1'b0);
		add_entry(SLT, 32'h8000_0000, 32'h7fff_ffff, 1'b0);
		add_entry(SLT, 32'h0000_0007, 32'h0000_0007, 1'b0);
		add_entry(SLL, 32'h0000_0001, 32'h0000_0000, 1'b0);
		add_entry(SLL, 32'h0000_0001, 32'h0000_001f, 1'b0); // into the sign bit
		add_entry(SLL, 32'h0000_0001, 32'h0000_0020, 1'b0); // exactly the width
		add_entry(SLL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		add_entry(SLL, 32'hdead_beef, 32'h0000_0100, 1'b0); // low bits zero but still too big
		add_entry(SLL, 32'hdead_beef, 32'h0000_0004, 1'b0);
		add_entry(NOP, 32'hdead_beef, 32'hffff_ffff, 1'b1);
		add_entry(NOP, 32'h0000_0000, 32'h0000_0000, 1'b0);
		add_entry(ADD, 32'h0000_0001, 32'h0000_0002, 1'b1);
		for (int k = 0; k < NUM_RANDOM; k++) begin
			rop = alu_op_t'(3'($urandom_range(0, 7)));
			ra  = W'($urandom());
			rb  = W'($urandom());
			if (rop == SLL && $urandom_range(0, 1) == 1)
				rb = W'($urandom_range(0, 40)); // mostly in-range shifts
			add_entry(rop, ra, rb, $urandom_range(0, 3) == 0);
		end
	endtask

	task automatic compare_outputs(input int idx);
		logic [3:0] got_flags;
		got_flags = {z, v, c, n};
		assert (result === tbl_exp_result[idx]) else begin
			value_errors++;
			$display("FAIL %0t: %s %h, %h gave result %h, expected %h", $time,
				tbl_op[idx].name(), tbl_a[idx], tbl_b[idx], result, tbl_exp_result[idx]);
		end
		assert (got_flags === tbl_exp_flags[idx]) else begin
			value_errors++;
			$display("FAIL %0t: %s %h, %h gave zvcn %b, expected %b", $time,
				tbl_op[idx].name(), tbl_a[idx], tbl_b[idx], got_flags, tbl_exp_flags[idx]);
		end
	endtask

	// scoreboard sees pre-edge values
	always @(posedge clk) begin
		if (!reset) begin
			if (pending.size() > 0) begin
				chk_idx = pending.pop_front();
				assert (result_valid) else begin
					protocol_errors++;
					$display("no result_valid one cycle after op_valid of entry %0d at %0t",
						chk_idx, $time);
				end
				if (result_valid) begin
					results_seen++;
					compare_outputs(chk_idx);
				end
				last_result = tbl_exp_result[chk_idx];
				last_flags  = tbl_exp_flags[chk_idx];
			end else begin
				assert (!result_valid) else begin
					protocol_errors++;
					$display("result_valid high at %0t with no operation outstanding", $time);
				end
				// idle cycles hold the last result and start from zeros after reset
				assert (result === last_result && {z, v, c, n} === last_flags) else begin
					value_errors++;
					$display("FAIL %0t: idle outputs %h %b, expected held %h %b", $time,
						result, {z, v, c, n}, last_result, last_flags);
				end
			end
			if (op_valid)
				pending.push_back(cur_idx);
		end
	end

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		op_valid        = 1'b0;
		operand0        = '0;
		operand1        = '0;
		op              = NOP;
		cur_idx         = 0;
		gap_count       = 0;
		results_seen    = 0;
		value_errors    = 0;
		protocol_errors = 0;
		last_result     = '0;
		last_flags      = '0;
		void'($urandom(SEED));
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		repeat (IDLE_CYCLES) @(posedge clk);

		for (int i = 0; i < tbl_op.size(); i++) begin
			if (tbl_gap[i]) begin
				@(posedge clk);
				op_valid <= 1'b0;
				op       <= alu_op_t'(3'($urandom_range(0, 7))); // junk that must not show
				operand0 <= W'($urandom());
				operand1 <= W'($urandom());
			end
			@(posedge clk);
			op_valid <= 1'b1;
			op       <= tbl_op[i];
			operand0 <= tbl_a[i];
			operand1 <= tbl_b[i];
			cur_idx  <= i;
		end
		@(posedge clk);
		op_valid <= 1'b0;
		repeat (3) @(posedge clk); // last result lands one edge later
		@(negedge clk);

		assert (results_seen == tbl_op.size()) else begin
			protocol_errors++;
			$display("saw %0d results for %0d operations", results_seen, tbl_op.size());
		end
		$display("errors: %0d value, %0d protocol, %0d of %0d results checked",
			value_errors, protocol_errors, results_seen, tbl_op.size());
		if (value_errors == 0 && protocol_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog sized from the table once it is built
	initial begin
		wait (table_ready);
		limit_ns = (tbl_op.size() + gap_count + RESET_CYCLES + IDLE_CYCLES + 50) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- alu_top.f
+incdir+rtl
+incdir+test
rtl/alu_pkg.sv
rtl/alu_arith_unit.sv
rtl/alu_logic_unit.sv
rtl/alu_result_combine.sv
rtl/alu_top.sv
test/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=alu_sim
LOG=sim.log

echo "building with verilator"
verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f alu_top.f \
	--top-module alu_tb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

echo "running simulation"
"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log, not from the exit code
if grep -qx '>>> PASS' "$LOG"; then
	echo "result: passed"
	exit 0
fi
echo "result: failed, see $LOG"
exit 1
